/* tb.f */
source/rob_pkg.sv
source/cdb_stage.sv
source/reorder_buffer.sv
source/retire_stage.sv
source/rob_top.sv
dv/tb_clock.sv
dv/rob_tb.sv

/* dv/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb;

    localparam int timeout_cycles = 200;

    typedef struct packed {
        logic [3:0]         tag;
        rob_pkg::op_class_e op;
        logic [4:0]         dest;
        logic [31:0]        pc;
        logic [31:0]        value;
        logic               taken;
        logic               pred;
        logic [31:0]        target;
    } exp_entry_t;

    logic                  clk;
    logic                  rst;
    logic                  alloc_valid;
    rob_pkg::op_class_e    alloc_op;
    logic [4:0]            alloc_dest;
    logic [31:0]           alloc_pc;
    logic                  alloc_pred_taken;
    logic                  alloc_ready;
    logic [3:0]            alloc_tag;
    logic                  alu_valid;
    rob_pkg::alu_result_t  alu_res;
    logic                  ld_valid;
    rob_pkg::load_result_t ld_res;
    logic [3:0]            q_tag1;
    logic [3:0]            q_tag2;
    logic                  q_ready1;
    logic                  q_ready2;
    logic [31:0]           q_value1;
    logic [31:0]           q_value2;
    logic                  reg_we;
    logic [4:0]            reg_dest;
    logic [3:0]            reg_tag;
    logic [31:0]           reg_value;
    logic [3:0]            store_commit_tag;
    logic                  bp_update;
    logic [31:0]           bp_pc;
    logic                  bp_taken;
    logic                  redirect;
    logic [31:0]           redirect_pc;

    // entries still waiting to retire in age order
    exp_entry_t  ref_q[$];
    exp_entry_t  by_tag [1:8];
    exp_entry_t  front;
    logic [3:0]  model_tail;
    logic [31:0] seed;
    logic        exp_has;
    logic        exp_we;
    logic        exp_store;
    logic        exp_bp;
    logic        exp_redirect;
    logic        any_retire;
    logic        live_retire;
    int          errors;
    int          tests;
    int          failed;
    int          test_errs;

    tb_clock u_clock (.clk(clk), .rst(rst));

    rob_top #(.rob_size(8)) uut (.*);

    assign any_retire  = reg_we || (store_commit_tag != 4'd0) || bp_update || redirect;
    assign live_retire = any_retire && exp_has;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] wrap_tag(input logic [3:0] t);
        return (t == 4'd8) ? 4'd1 : t + 4'd1;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        errors++;
        $display("[ERROR] %s expected %h got %h", name, exp, got);
    endtask

    task automatic report_plain(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else report_value(name, exp, got);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    // expected outcome of the oldest entry
    task automatic load_front;
        exp_has      = (ref_q.size() != 0);
        front        = exp_has ? ref_q[0] : '0;
        exp_we       = front.op inside {rob_pkg::op_alu, rob_pkg::op_load, rob_pkg::op_jalr};
        exp_store    = (front.op == rob_pkg::op_store);
        exp_bp       = (front.op == rob_pkg::op_branch) ||
                       (front.op == rob_pkg::op_jalr && front.taken);
        exp_redirect = (front.op == rob_pkg::op_jalr) ||
                       (front.op == rob_pkg::op_branch && front.taken != front.pred);
    endtask

    task automatic alloc_entry(input rob_pkg::op_class_e op, input logic pred,
                               input logic taken, output logic [3:0] tag);
        int cycles;
        exp_entry_t e;
        @(negedge clk);
        alloc_valid = 1'b0;
        cycles = 0;
        while (!alloc_ready && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        if (!alloc_ready) abort_on_timeout("alloc_ready");
        check_hex("alloc_tag", model_tail, alloc_tag);
        seed = lcg_step(seed);
        e.tag  = model_tail;
        e.op   = op;
        e.dest = seed[4:0];
        e.pc   = {seed[31:2], 2'b00};
        e.pred = pred;
        e.taken = taken;
        seed = lcg_step(seed);
        // jalr writes its link address
        e.value = (op == rob_pkg::op_jalr) ? e.pc + 32'd4 : seed;
        seed = lcg_step(seed);
        e.target = taken ? {seed[31:2], 2'b00} : e.pc + 32'd4;
        alloc_valid      = 1'b1;
        alloc_op         = op;
        alloc_dest       = e.dest;
        alloc_pc         = e.pc;
        alloc_pred_taken = pred;
        by_tag[e.tag] = e;
        ref_q.push_back(e);
        if (ref_q.size() == 1) load_front();
        model_tail = wrap_tag(model_tail);
        tag = e.tag;
    endtask

    task automatic stop_alloc;
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic drive_result(input logic [3:0] tag);
        exp_entry_t e;
        e = by_tag[tag];
        if (e.op == rob_pkg::op_load) begin
            ld_valid     = 1'b1;
            ld_res.tag   = tag;
            ld_res.value = e.value;
        end else begin
            alu_valid      = 1'b1;
            alu_res.tag    = tag;
            alu_res.value  = e.value;
            alu_res.taken  = e.taken;
            alu_res.target = e.target;
        end
    endtask

    // both buses in one cycle when the two results use different buses
    task automatic send_results(input logic [3:0] t_first, input logic [3:0] t_second);
        @(negedge clk);
        drive_result(t_first);
        if (t_second != 4'd0) begin
            if ((by_tag[t_first].op == rob_pkg::op_load) ==
                (by_tag[t_second].op == rob_pkg::op_load)) begin
                @(negedge clk);
                alu_valid = 1'b0;
                ld_valid  = 1'b0;
            end
            drive_result(t_second);
        end
        @(negedge clk);
        alu_valid = 1'b0;
        ld_valid  = 1'b0;
    endtask

    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (ref_q.size() != 0 && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        if (ref_q.size() != 0) abort_on_timeout("retirement of all entries");
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input int num, input string name);
        tests++;
        if (errors != test_errs) begin
            failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - test_errs);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
        test_errs = errors;
    endtask

    // retire pulses consume the oldest entry and a flush drops the rest
    always @(posedge clk) begin
        if (!rst && live_retire) begin
            if (exp_redirect) begin
                ref_q.delete();
                model_tail = 4'd1;
            end else begin
                void'(ref_q.pop_front());
            end
            load_front();
        end
    end

    a_retire_expected : assert property (@(posedge clk) disable iff (rst)
        any_retire |-> exp_has)
        else report_plain("retire output seen while no entry was due to retire");
    a_reg_we : assert property (@(posedge clk) disable iff (rst)
        live_retire |-> reg_we == exp_we)
        else report_value("reg_we", $sampled(exp_we), $sampled(reg_we));
    a_reg_tag : assert property (@(posedge clk) disable iff (rst)
        live_retire && reg_we |-> reg_tag == front.tag)
        else report_value("reg_tag", $sampled(front.tag), $sampled(reg_tag));
    a_reg_dest : assert property (@(posedge clk) disable iff (rst)
        live_retire && reg_we |-> reg_dest == front.dest)
        else report_value("reg_dest", $sampled(front.dest), $sampled(reg_dest));
    a_reg_value : assert property (@(posedge clk) disable iff (rst)
        live_retire && reg_we |-> reg_value == front.value)
        else report_value("reg_value", $sampled(front.value), $sampled(reg_value));
    a_store_tag : assert property (@(posedge clk) disable iff (rst)
        live_retire |-> store_commit_tag == (exp_store ? front.tag : 4'd0))
        else report_value("store_commit_tag", $sampled(exp_store ? front.tag : 4'd0),
                          $sampled(store_commit_tag));
    a_bp_update : assert property (@(posedge clk) disable iff (rst)
        live_retire |-> bp_update == exp_bp)
        else report_value("bp_update", $sampled(exp_bp), $sampled(bp_update));
    a_bp_pc : assert property (@(posedge clk) disable iff (rst)
        live_retire && bp_update |-> bp_pc == front.pc)
        else report_value("bp_pc", $sampled(front.pc), $sampled(bp_pc));
    a_bp_taken : assert property (@(posedge clk) disable iff (rst)
        live_retire && bp_update |-> bp_taken == front.taken)
        else report_value("bp_taken", $sampled(front.taken), $sampled(bp_taken));
    a_redirect : assert property (@(posedge clk) disable iff (rst)
        live_retire |-> redirect == exp_redirect)
        else report_value("redirect", $sampled(exp_redirect), $sampled(redirect));
    a_redirect_pc : assert property (@(posedge clk) disable iff (rst)
        live_retire && redirect |-> redirect_pc == front.target)
        else report_value("redirect_pc", $sampled(front.target), $sampled(redirect_pc));

    initial begin
        logic [3:0] t [0:7];
        int cycles;
        alloc_valid      = 1'b0;
        alloc_op         = rob_pkg::op_alu;
        alloc_dest       = '0;
        alloc_pc         = '0;
        alloc_pred_taken = 1'b0;
        alu_valid        = 1'b0;
        alu_res          = '0;
        ld_valid         = 1'b0;
        ld_res           = '0;
        q_tag1           = '0;
        q_tag2           = '0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        test_errs  = 0;
        seed       = 32'h79e3a6a9;
        model_tail = 4'd1;
        load_front();

        cycles = 0;
        @(negedge clk);
        while (rst && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        if (rst) abort_on_timeout("reset release");

        check_hex("alloc_ready", 1, alloc_ready);
        check_hex("alloc_tag", 1, alloc_tag);
        check_hex("reg_we", 0, reg_we);
        check_hex("store_commit_tag", 0, store_commit_tag);
        check_hex("bp_update", 0, bp_update);
        check_hex("redirect", 0, redirect);
        end_test(1, "reset state");

        for (int i = 0; i < 6; i++) begin
            alloc_entry((i % 2) ? rob_pkg::op_load : rob_pkg::op_alu, 1'b0, 1'b0, t[i]);
        end
        stop_alloc();
        for (int i = 5; i > 0; i -= 2) send_results(t[i], t[i-1]);
        wait_drain();
        end_test(2, "in-order retirement");

        for (int i = 0; i < 8; i++) begin
            seed = lcg_step(seed);
            alloc_entry(seed[9] ? rob_pkg::op_load : rob_pkg::op_alu, 1'b0, 1'b0, t[i]);
        end
        stop_alloc();
        check_hex("alloc_ready", 0, alloc_ready);
        // request held while full must not be taken
        alloc_valid = 1'b1;
        repeat (3) @(negedge clk);
        alloc_valid = 1'b0;
        check_hex("alloc_tag", model_tail, alloc_tag);
        for (int i = 7; i > 0; i -= 2) send_results(t[i], t[i-1]);
        wait_drain();
        alloc_entry(rob_pkg::op_alu, 1'b0, 1'b0, t[0]);
        stop_alloc();
        send_results(t[0], 4'd0);
        wait_drain();
        end_test(3, "full and wrap");

        alloc_entry(rob_pkg::op_alu, 1'b0, 1'b0, t[0]);
        alloc_entry(rob_pkg::op_load, 1'b0, 1'b0, t[1]);
        stop_alloc();
        q_tag1 = t[1];
        q_tag2 = 4'd0;
        drive_result(t[1]);
        @(negedge clk);
        alu_valid = 1'b0;
        ld_valid  = 1'b0;
        check_hex("q_ready1", 0, q_ready1);
        check_hex("q_ready2", 0, q_ready2);
        q_tag2 = t[0];
        @(negedge clk);
        check_hex("q_ready1", 1, q_ready1);
        check_hex("q_value1", by_tag[t[1]].value, q_value1);
        check_hex("q_ready2", 0, q_ready2);
        send_results(t[0], 4'd0);
        // second edge after the result, before the head pops
        @(negedge clk);
        check_hex("q_ready2", 1, q_ready2);
        check_hex("q_value2", by_tag[t[0]].value, q_value2);
        wait_drain();
        q_tag1 = 4'd0;
        q_tag2 = 4'd0;
        end_test(4, "operand query");

        alloc_entry(rob_pkg::op_store, 1'b0, 1'b0, t[0]);
        alloc_entry(rob_pkg::op_branch, 1'b1, 1'b1, t[1]);
        alloc_entry(rob_pkg::op_branch, 1'b0, 1'b0, t[2]);
        stop_alloc();
        send_results(t[0], t[1]);
        send_results(t[2], 4'd0);
        wait_drain();
        end_test(5, "store and branch");

        // branch predicted not taken resolves taken
        alloc_entry(rob_pkg::op_branch, 1'b0, 1'b1, t[0]);
        alloc_entry(rob_pkg::op_alu, 1'b0, 1'b0, t[1]);
        alloc_entry(rob_pkg::op_load, 1'b0, 1'b0, t[2]);
        stop_alloc();
        send_results(t[0], 4'd0);
        wait_drain();
        send_results(t[1], t[2]);
        repeat (4) @(negedge clk);
        alloc_entry(rob_pkg::op_jalr, 1'b0, 1'b1, t[0]);
        alloc_entry(rob_pkg::op_alu, 1'b0, 1'b0, t[1]);
        stop_alloc();
        send_results(t[1], t[0]);
        wait_drain();
        alloc_entry(rob_pkg::op_alu, 1'b0, 1'b0, t[0]);
        stop_alloc();
        send_results(t[0], 4'd0);
        wait_drain();
        end_test(6, "mispredict and jalr flush");

        $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 4 rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* source/rob_top.sv */
`timescale 1ns/1ps

module rob_top #(
    parameter int rob_size = 8,
    parameter int tag_w    = rob_pkg::tag_w
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_valid,
    input  rob_pkg::op_class_e           alloc_op,
    input  logic [rob_pkg::reg_w-1:0]    alloc_dest,
    input  logic [rob_pkg::data_w-1:0]   alloc_pc,
    input  logic                         alloc_pred_taken,
    output logic                         alloc_ready,
    output logic [tag_w-1:0]             alloc_tag,
    input  logic                         alu_valid,
    input  rob_pkg::alu_result_t         alu_res,
    input  logic                         ld_valid,
    input  rob_pkg::load_result_t        ld_res,
    input  logic [tag_w-1:0]             q_tag1,
    input  logic [tag_w-1:0]             q_tag2,
    output logic                         q_ready1,
    output logic                         q_ready2,
    output logic [rob_pkg::data_w-1:0]   q_value1,
    output logic [rob_pkg::data_w-1:0]   q_value2,
    output logic                         reg_we,
    output logic [rob_pkg::reg_w-1:0]    reg_dest,
    output logic [tag_w-1:0]             reg_tag,
    output logic [rob_pkg::data_w-1:0]   reg_value,
    output logic [tag_w-1:0]             store_commit_tag,
    output logic                         bp_update,
    output logic [rob_pkg::data_w-1:0]   bp_pc,
    output logic                         bp_taken,
    output logic                         redirect,
    output logic [rob_pkg::data_w-1:0]   redirect_pc
);

    // bus structs carry the package tag width
    if (tag_w != rob_pkg::tag_w) begin : g_bad_tag_w
        $error("rob_top: tag_w must equal rob_pkg::tag_w");
    end
    if (rob_size < 2 || rob_size >= (1 << tag_w)) begin : g_bad_size
        $error("rob_top: rob_size out of range for tag_w");
    end

    logic                         flush;
    logic                         alu_valid_q;
    rob_pkg::alu_result_t         alu_res_q;
    logic                         ld_valid_q;
    rob_pkg::load_result_t        ld_res_q;

    logic                         head_valid;
    logic [tag_w-1:0]             head_tag;
    rob_pkg::op_class_e           head_op;
    logic [rob_pkg::reg_w-1:0]    head_dest;
    logic [rob_pkg::data_w-1:0]   head_pc;
    logic [rob_pkg::data_w-1:0]   head_value;
    logic                         head_taken;
    logic [rob_pkg::data_w-1:0]   head_target;
    logic                         head_pred_taken;

    cdb_stage #(.payload_t(rob_pkg::alu_result_t)) u_alu_cdb (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(alu_valid), .in_payload(alu_res),
        .out_valid(alu_valid_q), .out_payload(alu_res_q)
    );

    cdb_stage #(.payload_t(rob_pkg::load_result_t)) u_ld_cdb (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(ld_valid), .in_payload(ld_res),
        .out_valid(ld_valid_q), .out_payload(ld_res_q)
    );

    reorder_buffer #(.rob_size(rob_size), .tag_w(tag_w)) u_rob (
        .clk(clk), .rst(rst), .flush(flush),
        .alloc_valid(alloc_valid), .alloc_op(alloc_op), .alloc_dest(alloc_dest),
        .alloc_pc(alloc_pc), .alloc_pred_taken(alloc_pred_taken),
        .alloc_ready(alloc_ready), .alloc_tag(alloc_tag),
        .alu_valid(alu_valid_q), .alu_res(alu_res_q),
        .ld_valid(ld_valid_q), .ld_res(ld_res_q),
        .q_tag1(q_tag1), .q_tag2(q_tag2), .q_ready1(q_ready1), .q_ready2(q_ready2),
        .q_value1(q_value1), .q_value2(q_value2),
        .head_valid(head_valid), .head_tag(head_tag), .head_op(head_op),
        .head_dest(head_dest), .head_pc(head_pc), .head_value(head_value),
        .head_taken(head_taken), .head_target(head_target),
        .head_pred_taken(head_pred_taken)
    );

    retire_stage #(.tag_w(tag_w)) u_retire (
        .clk(clk), .rst(rst),
        .head_valid(head_valid), .head_tag(head_tag), .head_op(head_op),
        .head_dest(head_dest), .head_pc(head_pc), .head_value(head_value),
        .head_taken(head_taken), .head_target(head_target),
        .head_pred_taken(head_pred_taken), .flush(flush),
        .reg_we(reg_we), .reg_dest(reg_dest), .reg_tag(reg_tag), .reg_value(reg_value),
        .store_commit_tag(store_commit_tag),
        .bp_update(bp_update), .bp_pc(bp_pc), .bp_taken(bp_taken),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

/* source/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage #(
    parameter int tag_w = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         head_valid,
    input  logic [tag_w-1:0]             head_tag,
    input  rob_pkg::op_class_e           head_op,
    input  logic [rob_pkg::reg_w-1:0]    head_dest,
    input  logic [rob_pkg::data_w-1:0]   head_pc,
    input  logic [rob_pkg::data_w-1:0]   head_value,
    input  logic                         head_taken,
    input  logic [rob_pkg::data_w-1:0]   head_target,
    input  logic                         head_pred_taken,
    output logic                         flush,
    output logic                         reg_we,
    output logic [rob_pkg::reg_w-1:0]    reg_dest,
    output logic [tag_w-1:0]             reg_tag,
    output logic [rob_pkg::data_w-1:0]   reg_value,
    output logic [tag_w-1:0]             store_commit_tag,
    output logic                         bp_update,
    output logic [rob_pkg::data_w-1:0]   bp_pc,
    output logic                         bp_taken,
    output logic                         redirect,
    output logic [rob_pkg::data_w-1:0]   redirect_pc
);

    logic is_branch;
    logic is_jalr;
    logic is_store;
    logic writes_reg;
    logic mispredict;
    logic updates_bp;

    assign is_branch  = (head_op == rob_pkg::op_branch);
    assign is_jalr    = (head_op == rob_pkg::op_jalr);
    assign is_store   = (head_op == rob_pkg::op_store);
    assign writes_reg = (head_op == rob_pkg::op_alu) || (head_op == rob_pkg::op_load) || is_jalr;
    assign mispredict = is_branch && (head_taken != head_pred_taken);
    assign updates_bp = is_branch || (is_jalr && head_taken);

    // jalr always redirects since its target is never predicted
    assign flush = head_valid && (is_jalr || mispredict);

    // pulses clear whenever nothing retires
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_we           <= 1'b0;
            store_commit_tag <= '0;
            bp_update        <= 1'b0;
            redirect         <= 1'b0;
        end else begin
            reg_we           <= head_valid && writes_reg;
            store_commit_tag <= (head_valid && is_store) ? head_tag : '0;
            bp_update        <= head_valid && updates_bp;
            redirect         <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid && writes_reg) begin
            reg_dest  <= head_dest;
            reg_tag   <= head_tag;
            reg_value <= head_value;
        end
        if (head_valid && updates_bp) begin
            bp_pc    <= head_pc;
            bp_taken <= head_taken;
        end
        // target already holds pc+4 for a branch resolved not taken
        if (flush) begin
            redirect_pc <= head_target;
        end
    end

    a_redirect_not_store : assert property (
        @(posedge clk) disable iff (rst)
        !(redirect && (store_commit_tag != '0))
    ) else $error("retire_stage: redirect and store commit together");

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_size = 8,
    parameter int tag_w    = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         alloc_valid,
    input  rob_pkg::op_class_e           alloc_op,
    input  logic [rob_pkg::reg_w-1:0]    alloc_dest,
    input  logic [rob_pkg::data_w-1:0]   alloc_pc,
    input  logic                         alloc_pred_taken,
    output logic                         alloc_ready,
    output logic [tag_w-1:0]             alloc_tag,
    input  logic                         alu_valid,
    input  rob_pkg::alu_result_t         alu_res,
    input  logic                         ld_valid,
    input  rob_pkg::load_result_t        ld_res,
    input  logic [tag_w-1:0]             q_tag1,
    input  logic [tag_w-1:0]             q_tag2,
    output logic                         q_ready1,
    output logic                         q_ready2,
    output logic [rob_pkg::data_w-1:0]   q_value1,
    output logic [rob_pkg::data_w-1:0]   q_value2,
    output logic                         head_valid,
    output logic [tag_w-1:0]             head_tag,
    output rob_pkg::op_class_e           head_op,
    output logic [rob_pkg::reg_w-1:0]    head_dest,
    output logic [rob_pkg::data_w-1:0]   head_pc,
    output logic [rob_pkg::data_w-1:0]   head_value,
    output logic                         head_taken,
    output logic [rob_pkg::data_w-1:0]   head_target,
    output logic                         head_pred_taken
);

    localparam int cnt_w = $clog2(rob_size + 1);

    // control state
    logic [rob_size:1]  valid_q;
    logic [rob_size:1]  ready_q;
    logic [tag_w-1:0]   head_q;
    logic [tag_w-1:0]   tail_q;
    logic [cnt_w-1:0]   count_q;

    // per-entry payload
    rob_pkg::op_class_e          op_q     [1:rob_size];
    logic [rob_pkg::reg_w-1:0]   dest_q   [1:rob_size];
    logic [rob_pkg::data_w-1:0]  pc_q     [1:rob_size];
    logic [rob_pkg::data_w-1:0]  value_q  [1:rob_size];
    logic                        taken_q  [1:rob_size];
    logic [rob_pkg::data_w-1:0]  target_q [1:rob_size];
    logic                        pred_q   [1:rob_size];

    logic               alloc_fire;
    logic [tag_w-1:0]   alu_tag;
    logic [tag_w-1:0]   ld_tag;
    logic               alu_hit;
    logic               ld_hit;

    function automatic logic tag_ok(input logic [tag_w-1:0] t);
        return (t != '0) && (t <= tag_w'(rob_size));
    endfunction

    // tags wrap from rob_size back to 1
    function automatic logic [tag_w-1:0] next_tag(input logic [tag_w-1:0] t);
        return (t == tag_w'(rob_size)) ? tag_w'(1) : t + tag_w'(1);
    endfunction

    assign alloc_ready = (count_q != cnt_w'(rob_size));
    assign alloc_tag   = tail_q;
    assign alloc_fire  = alloc_valid && alloc_ready;

    assign alu_tag = tag_w'(alu_res.tag);
    assign ld_tag  = tag_w'(ld_res.tag);
    // drop results for tag 0 or entries that are not live
    assign alu_hit = alu_valid && tag_ok(alu_tag) && valid_q[alu_tag];
    assign ld_hit  = ld_valid && tag_ok(ld_tag) && valid_q[ld_tag];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
            ready_q <= '0;
            head_q  <= tag_w'(1);
            tail_q  <= tag_w'(1);
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                valid_q[tail_q] <= 1'b1;
                ready_q[tail_q] <= 1'b0;
                tail_q          <= next_tag(tail_q);
            end
            if (alu_hit) begin
                ready_q[alu_tag] <= 1'b1;
            end
            if (ld_hit) begin
                ready_q[ld_tag] <= 1'b1;
            end
            // pop every cycle the head is done
            if (head_valid) begin
                valid_q[head_q] <= 1'b0;
                ready_q[head_q] <= 1'b0;
                head_q          <= next_tag(head_q);
            end
            count_q <= count_q + cnt_w'(alloc_fire) - cnt_w'(head_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            op_q[tail_q]   <= alloc_op;
            dest_q[tail_q] <= alloc_dest;
            pc_q[tail_q]   <= alloc_pc;
            pred_q[tail_q] <= alloc_pred_taken;
        end
        if (alu_hit) begin
            value_q[alu_tag]  <= alu_res.value;
            taken_q[alu_tag]  <= alu_res.taken;
            target_q[alu_tag] <= alu_res.target;
        end
        if (ld_hit) begin
            value_q[ld_tag] <= ld_res.value;
        end
    end

    // operand lookup for the decoder
    always_comb begin
        q_ready1 = tag_ok(q_tag1) && valid_q[q_tag1] && ready_q[q_tag1];
        q_ready2 = tag_ok(q_tag2) && valid_q[q_tag2] && ready_q[q_tag2];
        q_value1 = tag_ok(q_tag1) ? value_q[q_tag1] : '0;
        q_value2 = tag_ok(q_tag2) ? value_q[q_tag2] : '0;
    end

    assign head_valid      = valid_q[head_q] && ready_q[head_q];
    assign head_tag        = head_q;
    assign head_op         = op_q[head_q];
    assign head_dest       = dest_q[head_q];
    assign head_pc         = pc_q[head_q];
    assign head_value      = value_q[head_q];
    assign head_taken      = taken_q[head_q];
    assign head_target     = target_q[head_q];
    assign head_pred_taken = pred_q[head_q];

    a_count_bound : assert property (
        @(posedge clk) disable iff (rst)
        count_q <= cnt_w'(rob_size)
    ) else $error("reorder_buffer: count above rob_size");

    // a refused request must leave the tail where it was
    a_no_alloc_when_full : assert property (
        @(posedge clk) disable iff (rst)
        alloc_valid && !alloc_ready && !flush |=> $stable(tail_q)
    ) else $error("reorder_buffer: allocation taken while full");

    a_pop_was_ready : assert property (
        @(posedge clk) disable iff (rst)
        (head_q != $past(head_q)) && !$past(flush) && !$past(rst)
            |-> $past(valid_q[head_q] && ready_q[head_q])
    ) else $error("reorder_buffer: head popped before it was ready");

endmodule

/* source/cdb_stage.sv */
`timescale 1ns/1ps

module cdb_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // squashed on flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_payload <= in_payload;
        end
    end

    // a squashed result must never reach a reused tag
    a_no_valid_after_flush : assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !out_valid
    ) else $error("cdb_stage: result survived a flush");

endmodule

/* source/rob_pkg.sv */
package rob_pkg;

    // datapath widths
    localparam int data_w = 32;
    localparam int reg_w  = 5;

    // tag 0 is reserved as "no tag", so 4 bits give 15 usable entries
    localparam int tag_w  = 4;

    // retire behaviour of an entry, supplied by the decoder
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_load   = 3'd1,
        op_store  = 3'd2,
        op_branch = 3'd3,
        op_jalr   = 3'd4
    } op_class_e;

    // alu/branch result bus
    // target holds the resolved next pc for branches and jalr
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
        logic              taken;
        logic [data_w-1:0] target;
    } alu_result_t;

    // load result bus
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } load_result_t;

endpackage
